// File: include/memtest_cfg.svh
`ifndef MEMTEST_CFG_SVH
`define MEMTEST_CFG_SVH

////////////////////////////////////////////////////////////
// Soak test sizing
////////////////////////////////////////////////////////////

// Words exercised per pass, also the backing memory depth
`define MT_ADDR_COUNT 16

// Direct-mapped cache depth, power of two
`define MT_CACHE_LINES 16

// Idle cycles between one completion and the next request
`define MT_IDLE_GAP 4

// Backing memory response delay in cycles
`define MT_MEM_LATENCY 3

// Scrambling seed for the pattern table
`define MT_ROM_SEED 32'h5a3c96e1

`endif

// File: design/memtest_pkg.sv
package memtest_pkg;

	////////////////////////////////////////////////////////////
	// Widths shared across the soak tester
	////////////////////////////////////////////////////////////

	// One data word on either bus
	typedef logic [31:0] word_t;

	// Word address, same width as the pattern table address
	typedef logic [15:0] addr_t;

	// Passes completed over the address range
	typedef logic [7:0] pass_t;

	// Hit or miss statistic
	typedef logic [15:0] stat_t;

	// Traffic generator sequence, write then read per address
	typedef enum logic [2:0] {
		ISSUE_WR,
		WAIT_WR,
		GAP_WR,
		ISSUE_RD,
		WAIT_RD,
		GAP_RD,
		HALT
	} gen_state_t;

endpackage

// File: design/mem_req_if.sv
`timescale 1ns/1ps

// Request and completion bus between a requester and a responder
// Valid is held with its command until the one-cycle ready pulse
interface mem_req_if;

	// Command side
	logic valid;
	// 1 for write
	logic rw;
	memtest_pkg::addr_t addr;
	memtest_pkg::word_t wdata;

	// Completion side, rdata only meaningful with ready on a read
	memtest_pkg::word_t rdata;
	logic ready;

	modport requester (
		output valid,
		output rw,
		output addr,
		output wdata,
		input rdata,
		input ready
	);

	modport responder (
		input valid,
		input rw,
		input addr,
		input wdata,
		output rdata,
		output ready
	);

endinterface

// File: design/pattern_rom.sv
`timescale 1ns/1ps
`include "memtest_cfg.svh"

module pattern_rom (
	input logic clk,
	input memtest_pkg::addr_t addr,
	output memtest_pkg::word_t data
);

	localparam int DEPTH = `MT_ADDR_COUNT;
	localparam int IDX_W = $clog2(DEPTH);

	// Golden-ratio multiplier spreads bits between neighbours
	localparam logic [31:0] MIX = 32'h9e3779b9;

	memtest_pkg::word_t table_q [DEPTH];

	// Table built once at elaboration
	initial
	begin
		for (int i = 0; i < DEPTH; i++)
		begin
			table_q[i] = `MT_ROM_SEED ^ (32'(i) * MIX);
		end
	end

	// One-cycle registered read
	always_ff @(posedge clk)
	begin
		data <= table_q[addr[IDX_W-1:0]];
	end

endmodule

// File: design/dcache_traffic_gen.sv
`timescale 1ns/1ps
`include "memtest_cfg.svh"

module dcache_traffic_gen (
	input logic clk,
	input logic rst,
	output memtest_pkg::addr_t rom_addr,
	input memtest_pkg::word_t rom_data,
	mem_req_if.requester bus,
	output logic pass_done,
	output memtest_pkg::pass_t pass_count,
	output logic error,
	output memtest_pkg::addr_t err_addr
);

	localparam memtest_pkg::addr_t LAST_ADDR = memtest_pkg::addr_t'(`MT_ADDR_COUNT - 1);

	// ISSUE takes one of the idle cycles, GAP covers the rest
	localparam int GAP_LAST = (`MT_IDLE_GAP > 1) ? `MT_IDLE_GAP - 2 : 0;
	localparam bit HAS_GAP = (`MT_IDLE_GAP > 1);

	memtest_pkg::gen_state_t state;
	memtest_pkg::addr_t cur_addr;
	logic [7:0] gap_cnt;
	logic valid_q;
	logic rw_q;
	// Word written and later expected back
	memtest_pkg::word_t exp_q;

	// Address doubles as ROM index and bus address
	assign rom_addr = cur_addr;
	assign bus.addr = cur_addr;
	assign bus.valid = valid_q;
	assign bus.rw = rw_q;
	assign bus.wdata = exp_q;

	////////////////////////////////////////////////////////////
	// Sequencer
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= memtest_pkg::ISSUE_WR;
			cur_addr <= '0;
			gap_cnt <= '0;
			valid_q <= 1'b0;
			rw_q <= 1'b0;
			pass_done <= 1'b0;
			pass_count <= '0;
			error <= 1'b0;
			err_addr <= '0;
		end
		else
		begin
			// Strobe by default
			pass_done <= 1'b0;
			case (state)
				memtest_pkg::ISSUE_WR:
				begin
					valid_q <= 1'b1;
					rw_q <= 1'b1;
					state <= memtest_pkg::WAIT_WR;
				end
				memtest_pkg::WAIT_WR:
				begin
					if (bus.ready)
					begin
						valid_q <= 1'b0;
						gap_cnt <= '0;
						state <= HAS_GAP ? memtest_pkg::GAP_WR : memtest_pkg::ISSUE_RD;
					end
				end
				memtest_pkg::GAP_WR:
				begin
					if (gap_cnt == 8'(GAP_LAST))
						state <= memtest_pkg::ISSUE_RD;
					else
						gap_cnt <= gap_cnt + 8'd1;
				end
				memtest_pkg::ISSUE_RD:
				begin
					valid_q <= 1'b1;
					rw_q <= 1'b0;
					state <= memtest_pkg::WAIT_RD;
				end
				memtest_pkg::WAIT_RD:
				begin
					if (bus.ready)
					begin
						valid_q <= 1'b0;
						gap_cnt <= '0;
						if (bus.rdata != exp_q)
						begin
							// Sticky until reset
							error <= 1'b1;
							err_addr <= cur_addr;
							state <= memtest_pkg::HALT;
						end
						else
						begin
							state <= HAS_GAP ? memtest_pkg::GAP_RD : memtest_pkg::ISSUE_WR;
							// Wrap and start the next pass
							if (cur_addr == LAST_ADDR)
							begin
								cur_addr <= '0;
								pass_count <= pass_count + 8'd1;
								pass_done <= 1'b1;
							end
							else
								cur_addr <= cur_addr + 16'd1;
						end
					end
				end
				memtest_pkg::GAP_RD:
				begin
					// ROM lookup of the new address runs during this gap
					if (gap_cnt == 8'(GAP_LAST))
						state <= memtest_pkg::ISSUE_WR;
					else
						gap_cnt <= gap_cnt + 8'd1;
				end
				memtest_pkg::HALT:
				begin
					valid_q <= 1'b0;
				end
				default:
					state <= memtest_pkg::HALT;
			endcase
		end
	end

	// Pass number in every byte so stale lines show up
	always_ff @(posedge clk)
	begin
		if (state == memtest_pkg::ISSUE_WR)
			exp_q <= rom_data ^ {4{pass_count}};
	end

endmodule

// File: design/dcache.sv
`timescale 1ns/1ps
`include "memtest_cfg.svh"

module dcache (
	input logic clk,
	input logic rst,
	mem_req_if.responder cpu,
	mem_req_if.requester mem,
	output memtest_pkg::stat_t hit_count,
	output memtest_pkg::stat_t miss_count
);

	localparam int LINES = `MT_CACHE_LINES;
	localparam int IDX_W = $clog2(LINES);
	localparam int ADDR_W = $bits(memtest_pkg::addr_t);
	localparam int TAG_W = ADDR_W - IDX_W;

	typedef enum logic [1:0] {
		C_IDLE,
		C_MEM,
		C_RESP
	} cache_state_t;

	cache_state_t state;
	logic [LINES-1:0] line_valid;
	logic [TAG_W-1:0] tag_arr [LINES];
	memtest_pkg::word_t data_arr [LINES];
	logic [IDX_W-1:0] idx;
	logic [TAG_W-1:0] tag;
	logic hit;
	logic resp_hit;
	logic mem_valid;
	logic cpu_ready;
	memtest_pkg::word_t cpu_rdata;

	// Low bits pick the line, the rest is the tag
	assign idx = cpu.addr[IDX_W-1:0];
	assign tag = cpu.addr[ADDR_W-1:IDX_W];
	assign hit = line_valid[idx] && (tag_arr[idx] == tag);

	// Command fields stay steady while cpu valid is held
	assign mem.valid = mem_valid;
	assign mem.rw = cpu.rw;
	assign mem.addr = cpu.addr;
	assign mem.wdata = cpu.wdata;

	assign cpu.ready = cpu_ready;
	assign cpu.rdata = cpu_rdata;

	////////////////////////////////////////////////////////////
	// Control and statistics
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= C_IDLE;
			line_valid <= '0;
			mem_valid <= 1'b0;
			cpu_ready <= 1'b0;
			hit_count <= '0;
			miss_count <= '0;
		end
		else
		begin
			case (state)
				C_IDLE:
				begin
					if (cpu.valid)
					begin
						// Read hit served locally, anything else goes to memory
						if (!cpu.rw && hit)
						begin
							cpu_ready <= 1'b1;
							state <= C_RESP;
						end
						else
						begin
							mem_valid <= 1'b1;
							state <= C_MEM;
						end
					end
				end
				C_MEM:
				begin
					if (mem.ready)
					begin
						mem_valid <= 1'b0;
						cpu_ready <= 1'b1;
						state <= C_RESP;
						// Fill on read miss only, writes do not allocate
						if (!cpu.rw)
							line_valid[idx] <= 1'b1;
					end
				end
				C_RESP:
				begin
					cpu_ready <= 1'b0;
					state <= C_IDLE;
					// One count per completion
					if (resp_hit)
						hit_count <= hit_count + 16'd1;
					else
						miss_count <= miss_count + 16'd1;
				end
				default:
					state <= C_IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Line storage and response data
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (state == C_IDLE && cpu.valid && !cpu.rw && hit)
		begin
			cpu_rdata <= data_arr[idx];
			resp_hit <= 1'b1;
		end
		if (state == C_MEM && mem.ready)
		begin
			cpu_rdata <= mem.rdata;
			// Write hit decided here since the line cannot change meanwhile
			resp_hit <= hit;
			if (!cpu.rw)
			begin
				tag_arr[idx] <= tag;
				data_arr[idx] <= mem.rdata;
			end
			else if (hit)
				data_arr[idx] <= cpu.wdata;
		end
	end

endmodule

// File: design/backing_mem.sv
`timescale 1ns/1ps
`include "memtest_cfg.svh"

module backing_mem (
	input logic clk,
	input logic rst,
	mem_req_if.responder bus,
	input logic fault_en,
	input memtest_pkg::addr_t fault_addr
);

	localparam int DEPTH = `MT_ADDR_COUNT;
	localparam int IDX_W = $clog2(DEPTH);
	localparam int LAT = `MT_MEM_LATENCY;

	memtest_pkg::word_t mem_arr [DEPTH];
	memtest_pkg::word_t rdata_q;
	logic busy;
	logic ready_q;
	logic [7:0] lat_cnt;
	logic [IDX_W-1:0] idx;

	assign idx = bus.addr[IDX_W-1:0];
	assign bus.ready = ready_q;
	assign bus.rdata = rdata_q;

	// Ready lands LAT cycles after valid is first seen
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			ready_q <= 1'b0;
			lat_cnt <= '0;
		end
		else
		begin
			ready_q <= 1'b0;
			if (!busy && bus.valid)
			begin
				busy <= 1'b1;
				lat_cnt <= 8'd1;
			end
			else if (busy && !ready_q)
			begin
				if (lat_cnt == 8'(LAT - 1))
					ready_q <= 1'b1;
				lat_cnt <= lat_cnt + 8'd1;
			end
			else if (ready_q)
				busy <= 1'b0;
		end
	end

	// Read data staged one cycle ahead of ready
	always_ff @(posedge clk)
	begin
		if (busy && !ready_q && lat_cnt == 8'(LAT - 1))
			rdata_q <= mem_arr[idx];
		if (ready_q && bus.rw)
		begin
			// Injected fault flips bit 0 of the stored word
			if (fault_en && bus.addr == fault_addr)
				mem_arr[idx] <= bus.wdata ^ 32'h1;
			else
				mem_arr[idx] <= bus.wdata;
		end
	end

endmodule

// File: design/memtest_top.sv
`timescale 1ns/1ps

module memtest_top (
	input logic clk,
	input logic rst,
	input logic fault_en,
	input memtest_pkg::addr_t fault_addr,
	output logic error,
	output memtest_pkg::addr_t err_addr,
	output logic pass_done,
	output memtest_pkg::pass_t pass_count,
	output memtest_pkg::stat_t hit_count,
	output memtest_pkg::stat_t miss_count
);

	memtest_pkg::addr_t rom_addr;
	memtest_pkg::word_t rom_data;

	// Generator to cache, then cache to memory
	mem_req_if cpu_bus ();
	mem_req_if mem_bus ();

	////////////////////////////////////////////////////////////
	// Stimulus side
	////////////////////////////////////////////////////////////

	pattern_rom rom0 (
		.clk (clk),
		.addr (rom_addr),
		.data (rom_data)
	);

	dcache_traffic_gen gen0 (
		.clk (clk),
		.rst (rst),
		.rom_addr (rom_addr),
		.rom_data (rom_data),
		.bus (cpu_bus.requester),
		.pass_done (pass_done),
		.pass_count (pass_count),
		.error (error),
		.err_addr (err_addr)
	);

	////////////////////////////////////////////////////////////
	// Memory hierarchy under test
	////////////////////////////////////////////////////////////

	dcache cache0 (
		.clk (clk),
		.rst (rst),
		.cpu (cpu_bus.responder),
		.mem (mem_bus.requester),
		.hit_count (hit_count),
		.miss_count (miss_count)
	);

	backing_mem mem0 (
		.clk (clk),
		.rst (rst),
		.bus (mem_bus.responder),
		.fault_en (fault_en),
		.fault_addr (fault_addr)
	);

endmodule

// File: tb/tb_clkgen.sv
`timescale 1ns/1ps

// Free-running clock and power-on reset for the testbench
module tb_clkgen (
	output logic clk,
	output logic rst
);

	// 8 ns period
	localparam real HALF_PERIOD = 4.0;
	localparam int RESET_CYCLES = 3;

	logic rst_q = 1'b1;

	assign rst = rst_q;

	initial
	begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	// Held over three rising edges, released on the edge
	initial
	begin
		repeat (RESET_CYCLES) @(posedge clk);
		rst_q <= 1'b0;
	end

endmodule

// File: tb/tb_memtest.sv
`timescale 1ns/1ps
`include "memtest_cfg.svh"

module tb_memtest;

	localparam int N = `MT_ADDR_COUNT;
	localparam int ROWS = 4;
	localparam int HOLD_CYCLES = 200;
	localparam int RESET_CYCLES = 3;
	// Sum of passes in the table with one per fault row
	localparam int TOTAL_PASSES = 7;
	localparam int OP_CYCLES = `MT_IDLE_GAP + `MT_MEM_LATENCY + 4;
	localparam int LIMIT = 2 * TOTAL_PASSES * N * 2 * OP_CYCLES
		+ ROWS * (HOLD_CYCLES + 4 * RESET_CYCLES);

	// One stimulus row
	typedef struct {
		logic fault_en;
		memtest_pkg::addr_t fault_addr;
		int passes;
	} row_t;

	logic clk;
	logic por_rst;
	logic row_rst = 1'b0;
	logic rst;
	logic fault_en = 1'b0;
	memtest_pkg::addr_t fault_addr = '0;
	logic error;
	memtest_pkg::addr_t err_addr;
	logic pass_done;
	memtest_pkg::pass_t pass_count;
	memtest_pkg::stat_t hit_count;
	memtest_pkg::stat_t miss_count;

	row_t rows [ROWS];
	int cycles = 0;

	tb_clkgen clkgen0 (
		.clk (clk),
		.rst (por_rst)
	);

	// Power-on reset plus the reset between rows
	assign rst = por_rst | row_rst;

	memtest_top dut0 (
		.clk (clk),
		.rst (rst),
		.fault_en (fault_en),
		.fault_addr (fault_addr),
		.error (error),
		.err_addr (err_addr),
		.pass_done (pass_done),
		.pass_count (pass_count),
		.hit_count (hit_count),
		.miss_count (miss_count)
	);

	////////////////////////////////////////////////////////////
	// Reporting
	////////////////////////////////////////////////////////////

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("Result: FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			abort_run($sformatf("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp));
		end
	endtask

	// Run limit from the table length
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT)
			abort_run($sformatf("timeout after %0d cycles, test did not finish", LIMIT));
	end

	////////////////////////////////////////////////////////////
	// Row sequencing
	////////////////////////////////////////////////////////////

	// Clean rows alternate with faults at mid-range and at the last address
	task automatic load_table();
		rows[0] = '{1'b0, 16'd0, 3};
		rows[1] = '{1'b1, 16'd5, 1};
		rows[2] = '{1'b0, 16'd5, 2};
		rows[3] = '{1'b1, 16'(N - 1), 1};
	endtask

	task automatic apply_row_reset(input row_t row);
		@(posedge clk);
		fault_en <= row.fault_en;
		fault_addr <= row.fault_addr;
		row_rst <= 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		row_rst <= 1'b0;
		@(negedge clk);
		// Everything cleared by reset
		check_value("error", 32'(error), 32'h0);
		check_value("pass_count", 32'(pass_count), 32'h0);
		check_value("hit_count", 32'(hit_count), 32'h0);
		check_value("miss_count", 32'(miss_count), 32'h0);
	endtask

	// First pass misses every write and read, later passes hit on both
	task automatic run_clean_row(input int passes);
		int strobes;
		strobes = 0;
		while (strobes < passes)
		begin
			@(negedge clk);
			check_value("error", 32'(error), 32'h0);
			if (pass_done)
			begin
				strobes++;
				check_value("pass_count", 32'(pass_count), 32'(strobes));
				check_value("miss_count", 32'(miss_count), 32'(2 * N));
				check_value("hit_count", 32'(hit_count), 32'(2 * N * (strobes - 1)));
			end
		end
	endtask

	// Corrupted word caught on its read-back in pass 0
	task automatic run_fault_row(input memtest_pkg::addr_t addr);
		int exp_misses;
		// Write and read of each address up to the fault all miss
		exp_misses = 2 * (int'(addr) + 1);
		do
		begin
			@(negedge clk);
			check_value("pass_done", 32'(pass_done), 32'h0);
		end
		while (!error);
		check_value("err_addr", 32'(err_addr), 32'(addr));
		check_value("pass_count", 32'(pass_count), 32'h0);
		check_value("miss_count", 32'(miss_count), 32'(exp_misses));
		check_value("hit_count", 32'(hit_count), 32'h0);
		// Generator must stay halted
		repeat (HOLD_CYCLES)
		begin
			@(negedge clk);
			check_value("pass_done", 32'(pass_done), 32'h0);
			check_value("error", 32'(error), 32'h1);
			check_value("hit_count", 32'(hit_count), 32'h0);
			check_value("miss_count", 32'(miss_count), 32'(exp_misses));
		end
	endtask

	initial
	begin
		load_table();
		@(negedge clk);
		while (por_rst)
		begin
			@(negedge clk);
		end
		for (int r = 0; r < ROWS; r++)
		begin
			apply_row_reset(rows[r]);
			if (rows[r].fault_en)
				run_fault_row(rows[r].fault_addr);
			else
				run_clean_row(rows[r].passes);
		end
		$display("Result: PASSED");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+include
design/memtest_pkg.sv
design/mem_req_if.sv
design/pattern_rom.sv
design/dcache_traffic_gen.sv
design/dcache.sv
design/backing_mem.sv
design/memtest_top.sv
tb/tb_clkgen.sv
tb/tb_memtest.sv

// File: Makefile
# Verilator build and regression for the data-cache soak tester

VERILATOR ?= verilator
TOP ?= tb_memtest
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
HDRS := $(wildcard include/*.svh)
BIN := $(BUILD_DIR)/$(TOP)

.PHONY: all run check clean

all: check

# Rebuilt only when a source, header or the file list changes
$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)

run: $(BIN)
	-./$(BIN) 2>&1 | tee $(LOG)

check: run
	@if grep -q "Result: FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG) || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
